// File: Makefile
# Verilator build and run of the ADC pulse front end testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_pulse
FILELIST  ?= adc_pulse.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
FAIL_MSG  ?= Something failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation FAILED"; exit 1; \
	else \
	    echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: adc_pulse.f
+incdir+design
design/adc_pulse_pkg.sv
design/control_regs.sv
design/pulse_timer.sv
design/sample_assembler.sv
design/fifo_writer.sv
design/adc_pulse_top.sv
testbench/tb_adc_pulse.sv

// File: design/adc_pulse_consts.svh
`ifndef ADC_PULSE_CONSTS_SVH
`define ADC_PULSE_CONSTS_SVH

// one DDR half from the ADC pins
`define ADC_HALF_W 8
`define SAMPLE_W   16
// four samples per FIFO word
`define WORD_W     64

// register bus and counter widths
`define REG_W      32
`define REG_ADDR_W 3

// power-up settings
`define DEF_PERIOD 60000
`define DEF_STROBE 630
`define DEF_SOA    8

`endif

// File: design/adc_pulse_pkg.sv
`default_nettype none

package adc_pulse_pkg;

    // register map of the control bank
    typedef enum logic [2:0] {
        REG_PERIOD     = 3'd0,
        REG_ENABLE     = 3'd1,
        REG_STROBE     = 3'd2,
        REG_SOA        = 3'd3,
        REG_FIFO_RESET = 3'd4,
        REG_OVERFLOWS  = 3'd5
    } reg_addr_e;

    // which 16-bit slot of the FIFO word is filled this cycle
    typedef enum logic [1:0] {
        PH_TOP  = 2'd0,
        PH_LOW  = 2'd1,
        PH_MID  = 2'd2,
        PH_HIGH = 2'd3
    } pack_phase_e;

    // hold waits for the recorded position after a full FIFO
    typedef enum logic {
        WR_NORMAL = 1'b0,
        WR_HOLD   = 1'b1
    } writer_state_e;

endpackage

`default_nettype wire

// File: design/adc_pulse_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_pulse_consts.svh"

module adc_pulse_top (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     i_reg_wr,
    input  wire logic [`REG_ADDR_W-1:0]   i_reg_addr,
    input  wire logic [`REG_W-1:0]        i_reg_wdata,
    output logic      [`REG_W-1:0]        o_reg_rdata,
    input  wire logic [`ADC_HALF_W-1:0]   i_adc_rise,
    input  wire logic [`ADC_HALF_W-1:0]   i_adc_fall,
    input  wire logic                     i_fifo_full,
    output logic                          o_fifo_wr,
    output logic      [`WORD_W-1:0]       o_fifo_data,
    output logic                          o_fifo_reset,
    output logic                          o_strobe,
    output logic                          o_soa
);

    logic [`REG_W-1:0]          period;
    logic                       enable;
    logic [`REG_W-1:0]          strobe_len;
    logic [`REG_W-1:0]          soa_len;
    logic [`REG_W-1:0]          position;
    adc_pulse_pkg::pack_phase_e phase;
    logic                       period_wrap;
    logic [`SAMPLE_W-1:0]       sample;
    logic [`REG_W-1:0]          overflow_count;

    control_regs u_regs (
        .clk              (clk),
        .reset            (reset),
        .i_reg_wr         (i_reg_wr),
        .i_reg_addr       (adc_pulse_pkg::reg_addr_e'(i_reg_addr)),
        .i_reg_wdata      (i_reg_wdata),
        .i_overflow_count (overflow_count),
        .o_reg_rdata      (o_reg_rdata),
        .o_period         (period),
        .o_enable         (enable),
        .o_strobe_len     (strobe_len),
        .o_soa_len        (soa_len),
        .o_fifo_reset     (o_fifo_reset)
    );

    pulse_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .i_enable      (enable),
        .i_period      (period),
        .i_strobe_len  (strobe_len),
        .i_soa_len     (soa_len),
        .o_position    (position),
        .o_phase       (phase),
        .o_period_wrap (period_wrap),
        .o_strobe      (o_strobe),
        .o_soa         (o_soa)
    );

    sample_assembler u_assembler (
        .clk        (clk),
        .i_adc_rise (i_adc_rise),
        .i_adc_fall (i_adc_fall),
        .o_sample   (sample)
    );

    fifo_writer u_writer (
        .clk              (clk),
        .reset            (reset),
        .i_enable         (enable),
        .i_position       (position),
        .i_phase          (phase),
        .i_period_wrap    (period_wrap),
        .i_sample         (sample),
        .i_fifo_full      (i_fifo_full),
        .o_fifo_wr        (o_fifo_wr),
        .o_fifo_data      (o_fifo_data),
        .o_overflow_count (overflow_count)
    );

endmodule

`default_nettype wire

// File: design/control_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_pulse_consts.svh"

module control_regs (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     i_reg_wr,
    input  adc_pulse_pkg::reg_addr_e      i_reg_addr,
    input  wire logic [`REG_W-1:0]        i_reg_wdata,
    input  wire logic [`REG_W-1:0]        i_overflow_count,
    output logic      [`REG_W-1:0]        o_reg_rdata,
    output logic      [`REG_W-1:0]        o_period,
    output logic                          o_enable,
    output logic      [`REG_W-1:0]        o_strobe_len,
    output logic      [`REG_W-1:0]        o_soa_len,
    output logic                          o_fifo_reset
);

    // settings and the fifo reset pulse
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_period     <= `REG_W'(`DEF_PERIOD);
            o_enable     <= 1'b0;
            o_strobe_len <= `REG_W'(`DEF_STROBE);
            o_soa_len    <= `REG_W'(`DEF_SOA);
            o_fifo_reset <= 1'b0;
        end
        else
        begin
            // one pulse cycle for each write
            o_fifo_reset <= i_reg_wr && (i_reg_addr == adc_pulse_pkg::REG_FIFO_RESET);
            if (i_reg_wr)
            begin
                case (i_reg_addr)
                    adc_pulse_pkg::REG_PERIOD: o_period     <= i_reg_wdata;
                    adc_pulse_pkg::REG_ENABLE: o_enable     <= (i_reg_wdata != '0);
                    adc_pulse_pkg::REG_STROBE: o_strobe_len <= i_reg_wdata;
                    adc_pulse_pkg::REG_SOA:    o_soa_len    <= i_reg_wdata;
                    default:                   ;
                endcase
            end
        end
    end

    // readback, one cycle behind the address
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_reg_rdata <= '0;
        end
        else
        begin
            case (i_reg_addr)
                adc_pulse_pkg::REG_PERIOD:    o_reg_rdata <= o_period;
                adc_pulse_pkg::REG_ENABLE:    o_reg_rdata <= {{(`REG_W-1){1'b0}}, o_enable};
                adc_pulse_pkg::REG_STROBE:    o_reg_rdata <= o_strobe_len;
                adc_pulse_pkg::REG_SOA:       o_reg_rdata <= o_soa_len;
                adc_pulse_pkg::REG_OVERFLOWS: o_reg_rdata <= i_overflow_count;
                default:                      o_reg_rdata <= '0;
            endcase
        end
    end

    // the external FIFO sees a clean one-cycle reset
    a_fifo_reset_single: assert property (
        @(posedge clk) disable iff (!reset)
        o_fifo_reset |=> !o_fifo_reset
    );

endmodule

`default_nettype wire

// File: design/fifo_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_pulse_consts.svh"

module fifo_writer (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  i_enable,
    input  wire logic [`REG_W-1:0]     i_position,
    input  adc_pulse_pkg::pack_phase_e i_phase,
    input  wire logic                  i_period_wrap,
    input  wire logic [`SAMPLE_W-1:0]  i_sample,
    input  wire logic                  i_fifo_full,
    output logic                       o_fifo_wr,
    output logic      [`WORD_W-1:0]    o_fifo_data,
    output logic      [`REG_W-1:0]     o_overflow_count
);

    adc_pulse_pkg::writer_state_e state;
    logic [`REG_W-1:0]            hold_position;
    logic                         packing;

    // no slot is filled on the wrap cycle
    assign packing = i_enable && !i_period_wrap;

    // word assembly, slot order top, low, mid, high
    always_ff @(posedge clk)
    begin
        if (packing)
        begin
            case (i_phase)
                adc_pulse_pkg::PH_TOP:  o_fifo_data[63:48] <= i_sample;
                adc_pulse_pkg::PH_LOW:  o_fifo_data[15:0]  <= i_sample;
                adc_pulse_pkg::PH_MID:  o_fifo_data[31:16] <= i_sample;
                adc_pulse_pkg::PH_HIGH: o_fifo_data[47:32] <= i_sample;
                default:                ;
            endcase
        end
    end

    // write decision at the last slot
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_fifo_wr        <= 1'b0;
            state            <= adc_pulse_pkg::WR_NORMAL;
            hold_position    <= '0;
            o_overflow_count <= '0;
        end
        else if (!i_enable)
        begin
            // overflow count survives a disable
            o_fifo_wr     <= 1'b0;
            state         <= adc_pulse_pkg::WR_NORMAL;
            hold_position <= '0;
        end
        else if (packing && (i_phase == adc_pulse_pkg::PH_HIGH))
        begin
            if (i_fifo_full)
            begin
                o_fifo_wr        <= 1'b0;
                o_overflow_count <= o_overflow_count + 1'b1;
                if (state == adc_pulse_pkg::WR_NORMAL)
                begin
                    state         <= adc_pulse_pkg::WR_HOLD;
                    hold_position <= i_position;
                end
            end
            else if (state == adc_pulse_pkg::WR_NORMAL)
            begin
                o_fifo_wr <= 1'b1;
            end
            else if (i_position == hold_position)
            begin
                // resume at the same point of a later period
                o_fifo_wr     <= 1'b1;
                state         <= adc_pulse_pkg::WR_NORMAL;
                hold_position <= '0;
            end
            else
            begin
                o_fifo_wr <= 1'b0;
            end
        end
        else
        begin
            o_fifo_wr <= 1'b0;
        end
    end

    // the timer phase guarantees at least four cycles between words
    a_wr_single: assert property (
        @(posedge clk) disable iff (!reset)
        o_fifo_wr |=> !o_fifo_wr
    );

endmodule

`default_nettype wire

// File: design/pulse_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_pulse_consts.svh"

module pulse_timer (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  i_enable,
    input  wire logic [`REG_W-1:0]     i_period,
    input  wire logic [`REG_W-1:0]     i_strobe_len,
    input  wire logic [`REG_W-1:0]     i_soa_len,
    output logic      [`REG_W-1:0]     o_position,
    output adc_pulse_pkg::pack_phase_e o_phase,
    output logic                       o_period_wrap,
    output logic                       o_strobe,
    output logic                       o_soa
);

    logic [`REG_W-1:0] strobe_cnt;
    logic [`REG_W-1:0] soa_cnt;

    // last position of the period
    assign o_period_wrap = i_enable && (o_position == i_period);

    always_ff @(posedge clk)
    begin
        if (!reset || !i_enable)
        begin
            o_position <= '0;
            o_phase    <= adc_pulse_pkg::PH_TOP;
            strobe_cnt <= '0;
            soa_cnt    <= '0;
            o_strobe   <= 1'b0;
            o_soa      <= 1'b0;
        end
        else if (o_period_wrap)
        begin
            // new period, both pulses start here
            o_position <= '0;
            o_phase    <= adc_pulse_pkg::PH_TOP;
            strobe_cnt <= '0;
            soa_cnt    <= '0;
            o_strobe   <= 1'b1;
            o_soa      <= 1'b1;
        end
        else
        begin
            o_position <= o_position + 1'b1;
            o_phase    <= adc_pulse_pkg::pack_phase_e'(o_phase + 2'd1);
            // width+1 more cycles after the wrap cycle
            if (o_strobe && (strobe_cnt <= i_strobe_len))
            begin
                strobe_cnt <= strobe_cnt + 1'b1;
                o_strobe   <= 1'b1;
            end
            else
            begin
                o_strobe <= 1'b0;
            end
            if (o_soa && (soa_cnt <= i_soa_len))
            begin
                soa_cnt <= soa_cnt + 1'b1;
                o_soa   <= 1'b1;
            end
            else
            begin
                o_soa <= 1'b0;
            end
        end
    end

    a_quiet_when_disabled: assert property (
        @(posedge clk) disable iff (!reset)
        !i_enable |=> (!o_strobe && !o_soa)
    );

endmodule

`default_nettype wire

// File: design/sample_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_pulse_consts.svh"

module sample_assembler (
    input  wire logic                       clk,
    input  wire logic [`ADC_HALF_W-1:0]     i_adc_rise,
    input  wire logic [`ADC_HALF_W-1:0]     i_adc_fall,
    output logic      [`SAMPLE_W-1:0]       o_sample
);

    logic [`ADC_HALF_W-1:0] rise_q;
    logic [`ADC_HALF_W-1:0] fall_q;
    logic [`ADC_HALF_W-1:0] lane_odd;
    logic [`ADC_HALF_W-1:0] lane_even;

    // stage 1, capture both halves
    always_ff @(posedge clk)
    begin
        rise_q <= i_adc_rise;
        fall_q <= i_adc_fall;
    end

    // stage 2, rising half feeds the odd bits
    always_ff @(posedge clk)
    begin
        lane_odd  <= rise_q;
        lane_even <= fall_q;
    end

    // stage 3, bit interleave
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < `ADC_HALF_W; k++)
        begin
            o_sample[2*k+1] <= lane_odd[k];
            o_sample[2*k]   <= lane_even[k];
        end
    end

endmodule

`default_nettype wire

// File: testbench/adc_pulse_patterns.txt
# command and arguments, hex for wr rd word, decimal for the rest
# test name | wr addr data | rd addr expected | pulse strobe_hi soa_hi spacing | word rise fall expected | pack words random | ovf | quiet cycles | frst pulses
test reset_defaults
rd 0 0000ea60
rd 1 00000000
rd 2 00000276
rd 3 00000008
rd 5 00000000
rd 6 00000000
test reg_access
wr 0 00000028
wr 2 00000005
wr 3 00000002
rd 0 00000028
rd 2 00000005
rd 3 00000002
test pulse_widths
wr 1 00000001
pulse 7 4 41
test constant_words
word ff 00 aaaaaaaaaaaaaaaa
word 00 ff 5555555555555555
word f0 0f aa55aa55aa55aa55
test counter_pack
pack 12 0
test random_pack
wr 1 00000000
wr 0 0000002b
wr 1 00000001
pack 30 1
test overflow
ovf
rd 5 00000001
test disable
wr 1 00000000
rd 1 00000000
quiet 100
rd 5 00000001
test fifo_reset
frst 1

// File: testbench/tb_adc_pulse.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_pulse_consts.svh"

module tb_adc_pulse;

    localparam int WAIT_LIMIT  = 2000;
    localparam int MODE_CONST  = 0;
    localparam int MODE_COUNT  = 1;
    localparam int MODE_RANDOM = 2;

    logic                   clk;
    logic                   reset;
    logic                   i_reg_wr;
    logic [`REG_ADDR_W-1:0] i_reg_addr;
    logic [`REG_W-1:0]      i_reg_wdata;
    logic [`REG_W-1:0]      o_reg_rdata;
    logic [`ADC_HALF_W-1:0] i_adc_rise;
    logic [`ADC_HALF_W-1:0] i_adc_fall;
    logic                   i_fifo_full;
    logic                   o_fifo_wr;
    logic [`WORD_W-1:0]     o_fifo_data;
    logic                   o_fifo_reset;
    logic                   o_strobe;
    logic                   o_soa;

    int cyc;
    int errors;
    int checks;
    int timeouts;
    int en_cycle;
    int cur_period;
    int adc_mode;
    logic [31:0]            rnd;
    logic [`ADC_HALF_W-1:0] const_rise;
    logic [`ADC_HALF_W-1:0] const_fall;
    // expected sample for each driven cycle, indexed by cycle modulo 256
    logic [`SAMPLE_W-1:0]   hist [0:255];
    logic [8*24-1:0]        test_name;

    adc_pulse_top dut (
        .clk          (clk),
        .reset        (reset),
        .i_reg_wr     (i_reg_wr),
        .i_reg_addr   (i_reg_addr),
        .i_reg_wdata  (i_reg_wdata),
        .o_reg_rdata  (o_reg_rdata),
        .i_adc_rise   (i_adc_rise),
        .i_adc_fall   (i_adc_fall),
        .i_fifo_full  (i_fifo_full),
        .o_fifo_wr    (o_fifo_wr),
        .o_fifo_data  (o_fifo_data),
        .o_fifo_reset (o_fifo_reset),
        .o_strobe     (o_strobe),
        .o_soa        (o_soa)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // rise bit k lands on sample bit 2k+1, fall bit k on 2k
    function automatic logic [`SAMPLE_W-1:0] interleave(input logic [`ADC_HALF_W-1:0] rise,
                                                       input logic [`ADC_HALF_W-1:0] fall);
        logic [`SAMPLE_W-1:0] s;
        s = '0;
        for (int k = `ADC_HALF_W - 1; k >= 0; k--)
            s = {s[`SAMPLE_W-3:0], rise[k], fall[k]};
        return s;
    endfunction

    task automatic check_word(input string what, input logic [`WORD_W-1:0] expected,
                              input logic [`WORD_W-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED %0s %0s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_reg(input string what, input logic [`REG_W-1:0] expected,
                             input logic [`REG_W-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED %0s %0s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks++;
        if (actual != expected)
        begin
            errors++;
            $display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // one clock, then outputs are stable and the ADC halves for this cycle are driven
    task automatic step();
        @(posedge clk);
        #1;
        cyc = cyc + 1;
        if (adc_mode == MODE_RANDOM)
        begin
            rnd = xorshift(rnd);
            i_adc_rise = rnd[7:0];
            i_adc_fall = rnd[15:8];
        end
        else if (adc_mode == MODE_COUNT)
        begin
            i_adc_rise = cyc[7:0];
            i_adc_fall = cyc[15:8] ^ 8'h5a;
        end
        else
        begin
            i_adc_rise = const_rise;
            i_adc_fall = const_fall;
        end
        hist[cyc[7:0]] = interleave(i_adc_rise, i_adc_fall);
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        i_reg_wr    = 1'b1;
        i_reg_addr  = addr[`REG_ADDR_W-1:0];
        i_reg_wdata = data;
        step();
        i_reg_wr = 1'b0;
        // settings are live from this cycle, position 0 on enable
        if (addr == 32'd0)
            cur_period = int'(data);
        if (addr == 32'd1)
            en_cycle = cyc;
    endtask

    task automatic reg_read(input logic [31:0] addr, output logic [`REG_W-1:0] value);
        i_reg_addr = addr[`REG_ADDR_W-1:0];
        step();
        value = o_reg_rdata;
    endtask

    task automatic next_write(output int at, output bit ok);
        int n;
        ok = 1'b0;
        at = 0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT)
        begin
            step();
            n++;
            if (o_fifo_wr)
            begin
                ok = 1'b1;
                at = cyc;
            end
        end
        if (!ok)
        begin
            timeouts++;
            $display("timeout in test %0s: no FIFO write within %0d cycles",
                     test_name, WAIT_LIMIT);
        end
    endtask

    task automatic next_strobe_rise(output int at, output bit ok);
        int  n;
        logic prev;
        ok   = 1'b0;
        at   = 0;
        n    = 0;
        prev = o_strobe;
        while (!ok && n < WAIT_LIMIT)
        begin
            step();
            n++;
            if (o_strobe && !prev)
            begin
                ok = 1'b1;
                at = cyc;
            end
            prev = o_strobe;
        end
        if (!ok)
        begin
            timeouts++;
            $display("timeout in test %0s: strobe never rose", test_name);
        end
    endtask

    task automatic measure_pulses(input int strobe_hi, input int soa_hi, input int spacing);
        int r1;
        int r2;
        int s_hi;
        int o_hi;
        bit ok;
        next_strobe_rise(r1, ok);
        if (ok)
        begin
            s_hi = int'(o_strobe);
            o_hi = int'(o_soa);
            // rest of one full period
            repeat (cur_period)
            begin
                step();
                s_hi += int'(o_strobe);
                o_hi += int'(o_soa);
            end
            check_count("strobe high cycles", strobe_hi, s_hi);
            check_count("soa high cycles", soa_hi, o_hi);
            next_strobe_rise(r2, ok);
            if (ok)
                check_count("strobe edge spacing", spacing, r2 - r1);
        end
    endtask

    task automatic constant_word(input logic [7:0] rise, input logic [7:0] fall,
                                 input logic [`WORD_W-1:0] expected);
        int start;
        int w;
        bit ok;
        adc_mode   = MODE_CONST;
        const_rise = rise;
        const_fall = fall;
        start = cyc;
        ok    = 1'b1;
        w     = 0;
        // all four slots must come from the constant halves
        while (ok && w < start + 8)
            next_write(w, ok);
        if (ok)
            check_word("constant word", expected, o_fifo_data);
        adc_mode = MODE_COUNT;
    endtask

    task automatic pack_words(input int n, input bit use_random);
        int w;
        int pos;
        bit ok;
        logic [`WORD_W-1:0] expected;
        adc_mode = use_random ? MODE_RANDOM : MODE_COUNT;
        ok = 1'b1;
        for (int i = 0; i < n && ok; i++)
        begin
            next_write(w, ok);
            if (ok)
            begin
                // slots top, low, mid, high hold inputs of cycles w-7, w-6, w-5, w-4
                expected = {hist[8'(w - 7)], hist[8'(w - 4)], hist[8'(w - 5)], hist[8'(w - 6)]};
                check_word("packed word", expected, o_fifo_data);
                pos = (w - en_cycle) % (cur_period + 1);
                check_count("write position mod 4", 0, pos % 4);
            end
        end
        adc_mode = MODE_COUNT;
    endtask

    task automatic force_overflow();
        int w;
        int w2;
        int w3;
        int pos;
        int tries;
        bit ok;
        ok    = 1'b1;
        pos   = -1;
        tries = 0;
        // first write of a period, the next PH_HIGH is at position 7
        while (ok && pos != 4 && tries < WAIT_LIMIT)
        begin
            next_write(w, ok);
            pos = (w - en_cycle) % (cur_period + 1);
            tries++;
        end
        if (ok && pos != 4)
        begin
            ok = 1'b0;
            timeouts++;
            $display("timeout in test %0s: no FIFO write at position 4", test_name);
        end
        if (ok)
        begin
            i_fifo_full = 1'b1;
            repeat (4) step();
            i_fifo_full = 1'b0;
            check_count("write while full", 0, int'(o_fifo_wr));
            next_write(w2, ok);
            if (ok)
                check_count("resume cycle", w + 5 + cur_period, w2);
            if (ok)
                next_write(w3, ok);
            if (ok)
                check_count("write after resume", w2 + 4, w3);
        end
    endtask

    task automatic stay_quiet(input int n);
        int highs;
        highs = 0;
        repeat (n)
        begin
            step();
            if (o_strobe || o_soa || o_fifo_wr)
                highs++;
        end
        check_count("active cycles while disabled", 0, highs);
    endtask

    task automatic count_fifo_reset(input int expected);
        int pulses;
        reg_write(32'd4, 32'd1);
        pulses = int'(o_fifo_reset);
        repeat (5)
        begin
            step();
            pulses += int'(o_fifo_reset);
        end
        check_count("fifo reset cycles", expected, pulses);
    endtask

    initial
    begin
        int fd;
        int n;
        int da;
        int db;
        int dc;
        logic [8*256-1:0]   line;
        logic [63:0]        cmd;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [`WORD_W-1:0] c;
        logic [`REG_W-1:0]  rdval;

        reset       = 1'b0;
        i_reg_wr    = 1'b0;
        i_reg_addr  = '0;
        i_reg_wdata = '0;
        i_adc_rise  = '0;
        i_adc_fall  = '0;
        i_fifo_full = 1'b0;
        cyc         = 0;
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        en_cycle    = 0;
        cur_period  = `DEF_PERIOD;
        adc_mode    = MODE_COUNT;
        rnd         = 32'h8a62_4c61;
        const_rise  = '0;
        const_fall  = '0;
        test_name   = "startup";

        repeat (10) step();
        reset = 1'b1;
        repeat (2) step();

        fd = $fopen("testbench/adc_pulse_patterns.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the pattern file");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                cmd = '0;
                n = $sscanf(line, "%s", cmd);
                if (n == 1)
                begin
                    case (cmd)
                        64'("#"): ;
                        64'("test"): n = $sscanf(line, "%s %s", cmd, test_name);
                        64'("wr"):
                        begin
                            n = $sscanf(line, "%s %h %h", cmd, a, b);
                            reg_write(a, b);
                        end
                        64'("rd"):
                        begin
                            n = $sscanf(line, "%s %h %h", cmd, a, b);
                            reg_read(a, rdval);
                            check_reg("readback", b, rdval);
                        end
                        64'("pulse"):
                        begin
                            n = $sscanf(line, "%s %d %d %d", cmd, da, db, dc);
                            measure_pulses(da, db, dc);
                        end
                        64'("word"):
                        begin
                            n = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
                            constant_word(a[7:0], b[7:0], c);
                        end
                        64'("pack"):
                        begin
                            n = $sscanf(line, "%s %d %d", cmd, da, db);
                            pack_words(da, db != 0);
                        end
                        64'("ovf"): force_overflow();
                        64'("quiet"):
                        begin
                            n = $sscanf(line, "%s %d", cmd, da);
                            stay_quiet(da);
                        end
                        64'("frst"):
                        begin
                            n = $sscanf(line, "%s %d", cmd, da);
                            count_fifo_reset(da);
                        end
                        default:
                        begin
                            errors++;
                            $display("unknown command in the pattern file: %0s", cmd);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
